// File: src/i2c_bus_pkg.sv
package i2c_bus_pkg;

    // Widths seen on the wire
    typedef logic [6:0]  i2c_addr_t;       // 7-bit slave address
    typedef logic [7:0]  i2c_byte_t;       // One byte on SDA
    typedef logic [15:0] i2c_word_t;       // Up to two data bytes, MSB byte first
    typedef logic [3:0]  bit_idx_t;        // Bit position inside a word

    // Bit-level engine states
    typedef enum logic [3:0] {
        S_IDLE       = 4'd0,
        S_START      = 4'd1,
        S_ADDR       = 4'd2,
        S_RW         = 4'd3,
        S_SLAVE_ACK  = 4'd4,
        S_WRITE_MSB  = 4'd5,
        S_WRITE_LSB  = 4'd6,
        S_READ_MSB   = 4'd7,
        S_READ_LSB   = 4'd8,
        S_MASTER_ACK = 4'd9,
        S_STOP1      = 4'd10,
        S_STOP2      = 4'd11
    } bus_state_t;

    // First bit index of each data byte
    localparam bit_idx_t MSB_BYTE_TOP = 4'd15;
    localparam bit_idx_t MSB_BYTE_END = 4'd8;
    localparam bit_idx_t LSB_BYTE_TOP = 4'd7;

endpackage

// File: src/i2c_cmd_pkg.sv
package i2c_cmd_pkg;

    // One queued transfer, 25 bits
    typedef struct packed {
        i2c_bus_pkg::i2c_addr_t addr;      // Slave address
        logic                   rw;        // High for read
        logic                   two_bytes; // Two data bytes instead of one
        i2c_bus_pkg::i2c_word_t wdata;     // Write data, low byte in one-byte mode
    } i2c_cmd_t;

    // Outcome of one transfer, 17 bits
    typedef struct packed {
        i2c_bus_pkg::i2c_word_t rdata;     // Read data, MSB byte received first
        logic                   nack;      // Address or write byte not acknowledged
    } i2c_result_t;

    // Number of command entries in the queue
    typedef int unsigned queue_depth_t;

    localparam queue_depth_t DEFAULT_DEPTH = 4;

endpackage

// File: src/i2c_cmd_fifo.sv
`timescale 1ns/1ps

module i2c_cmd_fifo #(
    parameter i2c_cmd_pkg::queue_depth_t DEPTH = 4  // Power of two
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  i2c_cmd_pkg::i2c_cmd_t din,
    input  logic                  pop,
    output i2c_cmd_pkg::i2c_cmd_t head,
    output logic                  empty,
    output logic                  full
);

    localparam int AW = $clog2(DEPTH);

    typedef logic [AW-1:0] ptr_t;
    typedef logic [AW:0]   count_t;

    i2c_cmd_pkg::i2c_cmd_t mem [DEPTH];

    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    count_t count;
    logic   do_push;
    logic   do_pop;

    assign do_push = push && !full;  // Overflowing pushes are dropped
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == count_t'(DEPTH));
    assign head  = mem[rd_ptr];

    // Storage array
    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + ptr_t'(1);  // Wraps at DEPTH
            if (do_pop)
                rd_ptr <= rd_ptr + ptr_t'(1);
            // Push and pop together leave count alone
            if (do_push && !do_pop)
                count <= count + count_t'(1);
            else if (do_pop && !do_push)
                count <= count - count_t'(1);
        end
    end

endmodule

// File: src/i2c_cmd_sequencer.sv
`timescale 1ns/1ps

module i2c_cmd_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     empty,
    input  i2c_cmd_pkg::i2c_cmd_t    head,
    output logic                     pop,
    output logic                     start,
    output i2c_cmd_pkg::i2c_cmd_t    cmd,
    input  logic                     ready,
    input  i2c_cmd_pkg::i2c_result_t bus_result,
    output logic                     done,
    output i2c_cmd_pkg::i2c_result_t result
);

    typedef enum logic [1:0] {
        SEQ_WAIT   = 2'd0,
        SEQ_LAUNCH = 2'd1,
        SEQ_FINISH = 2'd2
    } seq_state_t;

    seq_state_t            state;
    i2c_cmd_pkg::i2c_cmd_t cmd_q;
    logic                  issue;

    // Pop and start go out together
    assign issue = (state == SEQ_WAIT) && !empty && ready;
    assign pop   = issue;
    assign start = issue;

    // Head feeds the engine on the start cycle, the held copy afterwards
    assign cmd = (state == SEQ_WAIT) ? head : cmd_q;

    always_ff @(posedge clk)
    begin
        if (issue)
            cmd_q <= head;
        if ((state == SEQ_FINISH) && ready)
            result <= bus_result;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= SEQ_WAIT;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                SEQ_WAIT:
                begin
                    if (issue)
                        state <= SEQ_LAUNCH;
                end
                SEQ_LAUNCH:
                begin
                    if (!ready)
                        state <= SEQ_FINISH;  // Engine has taken the command
                end
                SEQ_FINISH:
                begin
                    if (ready)
                    begin
                        state <= SEQ_WAIT;
                        done  <= 1'b1;  // Lines up with the registered result
                    end
                end
                default:
                    state <= SEQ_WAIT;
            endcase
        end
    end

endmodule

// File: src/i2c_bus_master.sv
`timescale 1ns/1ps

module i2c_bus_master (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  i2c_cmd_pkg::i2c_cmd_t    cmd,
    input  logic                     sda_in,
    output logic                     sda_low,
    output logic                     scl_low,
    output logic                     ready,
    output i2c_cmd_pkg::i2c_result_t result
);

    i2c_bus_pkg::bus_state_t state;
    i2c_bus_pkg::bus_state_t state_nxt;
    i2c_bus_pkg::bit_idx_t   cnt;
    i2c_bus_pkg::bit_idx_t   cnt_nxt;
    i2c_bus_pkg::i2c_byte_t  addr_byte;
    i2c_bus_pkg::i2c_word_t  rdata_q;
    i2c_cmd_pkg::i2c_cmd_t   cmd_q;

    logic sda_en;
    logic sda_en_nxt;
    logic scl_en;
    logic scl_en_nxt;
    logic data_phase;  // Address byte has been acknowledged
    logic two_q;       // Another data byte follows the current one
    logic nack_q;
    logic ready_q;

    assign addr_byte = {cmd_q.addr, cmd_q.rw};  // Address then R/W, MSB first

    assign sda_low = sda_en;
    // SCL is pulled low while clk is high, so it rises mid-bit on the falling edge
    assign scl_low = scl_en && clk;
    assign ready   = ready_q;

    assign result.rdata = rdata_q;
    assign result.nack  = nack_q;

    always_comb
    begin
        state_nxt  = state;
        cnt_nxt    = cnt;
        sda_en_nxt = 1'b0;  // SDA released unless a state pulls it
        scl_en_nxt = 1'b0;
        case (state)
            i2c_bus_pkg::S_IDLE:
            begin
                if (start)
                begin
                    state_nxt  = i2c_bus_pkg::S_START;
                    sda_en_nxt = 1'b1;  // Start, SDA falls with SCL high
                end
            end
            i2c_bus_pkg::S_START:
            begin
                state_nxt  = i2c_bus_pkg::S_ADDR;
                cnt_nxt    = i2c_bus_pkg::LSB_BYTE_TOP;
                sda_en_nxt = ~addr_byte[7];
                scl_en_nxt = 1'b1;
            end
            i2c_bus_pkg::S_ADDR:
            begin
                scl_en_nxt = 1'b1;
                if (cnt == 4'd1)
                begin
                    state_nxt  = i2c_bus_pkg::S_RW;
                    sda_en_nxt = ~addr_byte[0];
                end
                else
                begin
                    cnt_nxt    = cnt - 4'd1;
                    sda_en_nxt = ~addr_byte[cnt_nxt[2:0]];
                end
            end
            i2c_bus_pkg::S_RW:
            begin
                state_nxt  = i2c_bus_pkg::S_SLAVE_ACK;
                scl_en_nxt = 1'b1;
            end
            i2c_bus_pkg::S_SLAVE_ACK:
            begin
                scl_en_nxt = 1'b1;
                if (sda_in)
                begin
                    state_nxt  = i2c_bus_pkg::S_STOP1;  // No ACK
                    sda_en_nxt = 1'b1;
                end
                else if (!data_phase && cmd_q.rw)
                begin
                    state_nxt = cmd_q.two_bytes ? i2c_bus_pkg::S_READ_MSB
                                                : i2c_bus_pkg::S_READ_LSB;
                    cnt_nxt   = cmd_q.two_bytes ? i2c_bus_pkg::MSB_BYTE_TOP
                                                : i2c_bus_pkg::LSB_BYTE_TOP;
                end
                else if (!data_phase)
                begin
                    state_nxt  = cmd_q.two_bytes ? i2c_bus_pkg::S_WRITE_MSB
                                                 : i2c_bus_pkg::S_WRITE_LSB;
                    cnt_nxt    = cmd_q.two_bytes ? i2c_bus_pkg::MSB_BYTE_TOP
                                                 : i2c_bus_pkg::LSB_BYTE_TOP;
                    sda_en_nxt = ~cmd_q.wdata[cnt_nxt];
                end
                else if (two_q)
                begin
                    state_nxt  = i2c_bus_pkg::S_WRITE_LSB;  // Second write byte
                    cnt_nxt    = i2c_bus_pkg::LSB_BYTE_TOP;
                    sda_en_nxt = ~cmd_q.wdata[cnt_nxt];
                end
                else
                begin
                    state_nxt  = i2c_bus_pkg::S_STOP1;
                    sda_en_nxt = 1'b1;
                end
            end
            i2c_bus_pkg::S_WRITE_MSB, i2c_bus_pkg::S_WRITE_LSB:
            begin
                scl_en_nxt = 1'b1;
                if ((state == i2c_bus_pkg::S_WRITE_MSB && cnt == i2c_bus_pkg::MSB_BYTE_END) ||
                    (state == i2c_bus_pkg::S_WRITE_LSB && cnt == 4'd0))
                begin
                    state_nxt = i2c_bus_pkg::S_SLAVE_ACK;
                end
                else
                begin
                    cnt_nxt    = cnt - 4'd1;
                    sda_en_nxt = ~cmd_q.wdata[cnt_nxt];
                end
            end
            i2c_bus_pkg::S_READ_MSB:
            begin
                scl_en_nxt = 1'b1;
                if (cnt == i2c_bus_pkg::MSB_BYTE_END)
                begin
                    state_nxt  = i2c_bus_pkg::S_MASTER_ACK;
                    sda_en_nxt = 1'b1;  // ACK, one more byte wanted
                end
                else
                    cnt_nxt = cnt - 4'd1;
            end
            i2c_bus_pkg::S_READ_LSB:
            begin
                scl_en_nxt = 1'b1;
                if (cnt == 4'd0)
                    state_nxt = i2c_bus_pkg::S_MASTER_ACK;  // Left high, last byte
                else
                    cnt_nxt = cnt - 4'd1;
            end
            i2c_bus_pkg::S_MASTER_ACK:
            begin
                scl_en_nxt = 1'b1;
                if (two_q)
                begin
                    state_nxt = i2c_bus_pkg::S_READ_LSB;
                    cnt_nxt   = i2c_bus_pkg::LSB_BYTE_TOP;
                end
                else
                begin
                    state_nxt  = i2c_bus_pkg::S_STOP1;
                    sda_en_nxt = 1'b1;
                end
            end
            i2c_bus_pkg::S_STOP1:
            begin
                state_nxt  = i2c_bus_pkg::S_STOP2;
                sda_en_nxt = 1'b1;  // SCL goes high, SDA still low
            end
            i2c_bus_pkg::S_STOP2:
                state_nxt = i2c_bus_pkg::S_IDLE;  // SDA rises, stop
            default:
                state_nxt = i2c_bus_pkg::S_IDLE;
        endcase
    end

    // Command copy and read word
    always_ff @(posedge clk)
    begin
        if (state == i2c_bus_pkg::S_IDLE)
            cmd_q <= cmd;
        if (state == i2c_bus_pkg::S_IDLE && start)
            rdata_q <= '0;  // High byte stays zero in one-byte reads
        else if (state == i2c_bus_pkg::S_READ_MSB || state == i2c_bus_pkg::S_READ_LSB)
            rdata_q[cnt] <= sda_in;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= i2c_bus_pkg::S_IDLE;
            cnt        <= '0;
            sda_en     <= 1'b0;
            scl_en     <= 1'b0;
            data_phase <= 1'b0;
            two_q      <= 1'b0;
            nack_q     <= 1'b0;
            ready_q    <= 1'b0;
        end
        else
        begin
            state   <= state_nxt;
            cnt     <= cnt_nxt;
            sda_en  <= sda_en_nxt;
            scl_en  <= scl_en_nxt;
            ready_q <= (state_nxt == i2c_bus_pkg::S_IDLE);
            case (state)
                i2c_bus_pkg::S_IDLE:
                begin
                    if (start)
                    begin
                        data_phase <= 1'b0;
                        nack_q     <= 1'b0;
                    end
                end
                i2c_bus_pkg::S_SLAVE_ACK:
                begin
                    if (sda_in)
                        nack_q <= 1'b1;
                    else if (!data_phase)
                    begin
                        data_phase <= 1'b1;
                        two_q      <= cmd_q.two_bytes;
                    end
                    else
                        two_q <= 1'b0;
                end
                i2c_bus_pkg::S_MASTER_ACK:
                    two_q <= 1'b0;
                default:
                begin
                end
            endcase
        end
    end

endmodule

// File: src/i2c_ctrl_top.sv
`timescale 1ns/1ps

module i2c_ctrl_top #(
    parameter i2c_cmd_pkg::queue_depth_t FIFO_DEPTH = i2c_cmd_pkg::DEFAULT_DEPTH
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cmd_push,
    input  i2c_cmd_pkg::i2c_cmd_t    cmd,
    output logic                     cmd_full,
    output logic                     done,
    output i2c_cmd_pkg::i2c_result_t result,
    output logic                     sda_low,
    output logic                     scl_low,
    input  logic                     sda_in
);

    i2c_cmd_pkg::i2c_cmd_t    head;
    i2c_cmd_pkg::i2c_cmd_t    bus_cmd;
    i2c_cmd_pkg::i2c_result_t bus_result;

    logic cmd_empty;
    logic pop;
    logic start;
    logic ready;

    i2c_cmd_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (cmd_push),
        .din   (cmd),
        .pop   (pop),
        .head  (head),
        .empty (cmd_empty),
        .full  (cmd_full)
    );

    i2c_cmd_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .empty      (cmd_empty),
        .head       (head),
        .pop        (pop),
        .start      (start),
        .cmd        (bus_cmd),
        .ready      (ready),
        .bus_result (bus_result),
        .done       (done),
        .result     (result)
    );

    i2c_bus_master u_master (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .cmd     (bus_cmd),
        .sda_in  (sda_in),
        .sda_low (sda_low),
        .scl_low (scl_low),
        .ready   (ready),
        .result  (bus_result)
    );

endmodule

// File: test/i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model #(
    parameter logic [6:0] ADDR = 7'h2a
) (
    input  logic scl,
    input  logic sda,
    output logic sda_low
);

    logic [7:0] regs [0:255];
    logic [7:0] shift;
    logic [7:0] tx_byte;
    logic [7:0] ptr;
    logic [3:0] bit_cnt;
    logic [1:0] byte_no;     // Saturates at 2, only first bytes matter
    logic       addressed;
    logic       tx_on;       // Slave is sending read data
    logic       ack_due;
    logic       prev_scl;
    logic       prev_sda;

    task automatic clear_frame();
        bit_cnt   = 4'd0;
        byte_no   = 2'd0;
        addressed = 1'b0;
        tx_on     = 1'b0;
        ack_due   = 1'b0;
    endtask

    // Handles one received byte
    task automatic take_byte();
        if (byte_no == 2'd0)
        begin
            addressed = (shift[7:1] == ADDR);
            tx_on     = addressed && shift[0];
            ack_due   = addressed;
        end
        else if (addressed && !tx_on)
        begin
            if (byte_no == 2'd1)
                ptr = shift;  // First write byte is the register pointer
            else
            begin
                regs[ptr] = shift;
                ptr = ptr + 8'd1;
            end
            ack_due = 1'b1;
        end
        if (byte_no != 2'd2)
            byte_no = byte_no + 2'd1;
    endtask

    initial
    begin
        for (int i = 0; i < 256; i++)
            regs[i] = 8'(i) ^ 8'h5a;
        sda_low  = 1'b0;
        ptr      = 8'd0;
        shift    = 8'd0;
        tx_byte  = 8'd0;
        prev_scl = 1'b1;
        prev_sda = 1'b1;
        clear_frame();
        forever
        begin
            @(scl or sda);
            #1;  // Let edges from the same clock settle
            if (prev_scl === 1'b1 && scl === 1'b1 && prev_sda !== sda)
            begin
                clear_frame();  // Start or stop
            end
            else if (prev_scl === 1'b0 && scl === 1'b1)
            begin
                if (bit_cnt == 4'd8)
                begin
                    if (tx_on && !ack_due && sda)
                        tx_on = 1'b0;  // Master NACK ends the read
                    ack_due = 1'b0;
                    bit_cnt = 4'd0;
                end
                else
                begin
                    shift   = {shift[6:0], sda};
                    bit_cnt = bit_cnt + 4'd1;
                    if (bit_cnt == 4'd8 && !(tx_on && byte_no != 2'd0))
                        take_byte();
                end
            end
            else if (prev_scl === 1'b1 && scl === 1'b0)
            begin
                prev_scl = scl;
                prev_sda = sda;
                #4;
                if (bit_cnt == 4'd8 && ack_due)
                    sda_low = 1'b1;
                else if (bit_cnt < 4'd8 && tx_on && byte_no != 2'd0)
                begin
                    if (bit_cnt == 4'd0)
                    begin
                        tx_byte = regs[ptr];
                        ptr = ptr + 8'd1;
                    end
                    sda_low = ~tx_byte[7];
                    tx_byte = {tx_byte[6:0], 1'b0};
                end
                else
                    sda_low = 1'b0;
            end
            prev_scl = scl;
            prev_sda = sda;
        end
    end

endmodule

// File: test/i2c_ctrl_checker.sv
`timescale 1ns/1ps

module i2c_ctrl_checker (
    input logic                    clk,
    input logic                    rst,
    input logic                    cmd_push,
    input logic                    cmd_full,
    input logic                    start,
    input logic                    ready,
    input logic                    done,
    input logic                    sda_low,
    input logic                    scl_low,
    input i2c_bus_pkg::bus_state_t bus_state
);

    logic seen_push;
    int   fail_count = 0;

    always_ff @(posedge clk)
    begin
        if (rst)
            seen_push <= 1'b0;
        else if (cmd_push)
            seen_push <= 1'b1;
    end

    // Sampled on the falling edge, where scl_low shows the engine's SCL enable
    assert property (@(negedge clk) disable iff (rst)
        !seen_push |-> (!sda_low && !scl_low && !done))
        else
        begin
            fail_count++;
            $error("bus not idle before the first push");
        end

    assert property (@(negedge clk) disable iff (rst)
        cmd_push |-> !cmd_full)
        else
        begin
            fail_count++;
            $error("command pushed while the queue is full");
        end

    // Engine must really sit in idle when a command is launched
    assert property (@(negedge clk) disable iff (rst)
        start |-> (bus_state == i2c_bus_pkg::S_IDLE))
        else
        begin
            fail_count++;
            $error("start issued while the engine is busy");
        end

    assert property (@(negedge clk) disable iff (rst)
        start |=> !ready)
        else
        begin
            fail_count++;
            $error("engine did not take the started command");
        end

    // SDA moves with SCL high only for start from idle or stop into idle
    assert property (@(negedge clk) disable iff (rst)
        ($changed(sda_low) && !scl_low) |->
            (($rose(sda_low) && $past(ready)) || ($fell(sda_low) && ready)))
        else
        begin
            fail_count++;
            $error("SDA changed while SCL was high outside start or stop");
        end

endmodule

// File: test/tb_i2c_ctrl.sv
`timescale 1ns/1ps

module tb_i2c_ctrl;

    localparam int NUM_CMDS    = 12;
    localparam int CMD_CYCLES  = 40;
    localparam int PERIOD      = 100;
    localparam int WATCHDOG_NS = (NUM_CMDS * CMD_CYCLES + 200) * PERIOD;

    logic                     clk;
    logic                     rst;
    logic                     cmd_push;
    i2c_cmd_pkg::i2c_cmd_t    cmd;
    logic                     cmd_full;
    logic                     done;
    i2c_cmd_pkg::i2c_result_t result;
    logic                     sda_low;
    logic                     scl_low;
    logic                     slave_sda_low;
    logic                     sda_line;
    logic                     scl_line;

    i2c_cmd_pkg::i2c_result_t results [$];
    i2c_cmd_pkg::i2c_result_t r;
    integer                   seed;
    integer                   rnd;
    int                       errors;
    int                       tests;
    int                       failed;
    int                       err_mark;
    int                       chk_mark;
    logic                     full_seen;
    logic [7:0]               ptr2;
    logic [7:0]               val2;
    logic [7:0]               val3;
    logic [7:0]               pa;
    logic [7:0]               va;

    assign sda_line = !(sda_low || slave_sda_low);  // Wired-AND
    assign scl_line = !scl_low;

    i2c_ctrl_top #(
        .FIFO_DEPTH (4)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .cmd_push (cmd_push),
        .cmd      (cmd),
        .cmd_full (cmd_full),
        .done     (done),
        .result   (result),
        .sda_low  (sda_low),
        .scl_low  (scl_low),
        .sda_in   (sda_line)
    );

    i2c_slave_model #(
        .ADDR (7'h2a)
    ) u_slave (
        .scl     (scl_line),
        .sda     (sda_line),
        .sda_low (slave_sda_low)
    );

    bind i2c_ctrl_top i2c_ctrl_checker u_checker (
        .clk       (clk),
        .rst       (rst),
        .cmd_push  (cmd_push),
        .cmd_full  (cmd_full),
        .start     (start),
        .ready     (ready),
        .done      (done),
        .sda_low   (sda_low),
        .scl_low   (scl_low),
        .bus_state (u_master.state)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

    // Result capture and full tracking
    always @(posedge clk)
    begin
        if (done)
            results.push_back(result);
        if (cmd_full)
            full_seen <= 1'b1;
    end

    function automatic i2c_cmd_pkg::i2c_cmd_t make_cmd(logic [6:0] addr, logic rw,
                                                        logic two, logic [15:0] wdata);
        i2c_cmd_pkg::i2c_cmd_t c;
        c.addr      = addr;
        c.rw        = rw;
        c.two_bytes = two;
        c.wdata     = wdata;
        return c;
    endfunction

    task automatic check_value(string name, logic [15:0] exp, logic [15:0] got);
        assert (got === exp)
        else
        begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic push_cmd(i2c_cmd_pkg::i2c_cmd_t c);
        while (cmd_full)
        begin
            @(posedge clk);
            #1;
        end
        cmd_push = 1'b1;
        cmd      = c;
        @(posedge clk);
        #1;
        cmd_push = 1'b0;
    endtask

    task automatic wait_result(output i2c_cmd_pkg::i2c_result_t res);
        while (results.size() == 0)
        begin
            @(posedge clk);
            #1;
        end
        res = results.pop_front();
    endtask

    task automatic run_cmd(i2c_cmd_pkg::i2c_cmd_t c, output i2c_cmd_pkg::i2c_result_t res);
        push_cmd(c);
        wait_result(res);
    endtask

    task automatic end_test(string name);
        int chk_now;
        chk_now  = u_dut.u_checker.fail_count;
        errors   = errors + (chk_now - chk_mark);
        chk_mark = chk_now;
        tests++;
        if (errors == err_mark)
            $display("test %s: ok", name);
        else
        begin
            failed++;
            $display("test %s: failed", name);
        end
        err_mark = errors;
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        rst       = 1'b1;
        cmd_push  = 1'b0;
        cmd       = '0;
        full_seen = 1'b0;
        seed      = 32'h13df;
        errors    = 0;
        tests     = 0;
        failed    = 0;
        err_mark  = 0;
        chk_mark  = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (3) @(posedge clk);
        #1;
        check_value("done", 16'd0, {15'd0, done});
        check_value("sda_low", 16'd0, {15'd0, sda_low});
        check_value("scl_low", 16'd0, {15'd0, scl_low});
        check_value("sda_line", 16'd1, {15'd0, sda_line});
        check_value("scl_line", 16'd1, {15'd0, scl_line});
        end_test("reset_idle");

        rnd  = $random(seed);
        ptr2 = rnd[7:0];
        rnd  = $random(seed);
        val2 = rnd[7:0];
        run_cmd(make_cmd(7'h2a, 1'b0, 1'b1, {ptr2, val2}), r);
        check_value("result.nack", 16'd0, {15'd0, r.nack});
        check_value("slave.regs", {8'd0, val2}, {8'd0, u_slave.regs[ptr2]});
        end_test("two_byte_write");

        run_cmd(make_cmd(7'h2a, 1'b0, 1'b0, {8'd0, ptr2}), r);
        run_cmd(make_cmd(7'h2a, 1'b1, 1'b0, 16'd0), r);
        check_value("result.rdata", {8'd0, val2}, r.rdata);
        check_value("result.nack", 16'd0, {15'd0, r.nack});
        rnd  = $random(seed);
        val3 = rnd[7:0];
        run_cmd(make_cmd(7'h2a, 1'b0, 1'b1, {ptr2 + 8'd1, val3}), r);
        run_cmd(make_cmd(7'h2a, 1'b0, 1'b0, {8'd0, ptr2}), r);
        run_cmd(make_cmd(7'h2a, 1'b1, 1'b1, 16'd0), r);
        check_value("result.rdata", {val2, val3}, r.rdata);
        end_test("reads");

        run_cmd(make_cmd(7'h13, 1'b0, 1'b1, 16'h1234), r);
        check_value("result.nack", 16'd1, {15'd0, r.nack});
        check_value("sda_line", 16'd1, {15'd0, sda_line});
        check_value("scl_line", 16'd1, {15'd0, scl_line});
        end_test("absent_address");

        rnd = $random(seed);
        pa  = rnd[7:0];
        rnd = $random(seed);
        va  = rnd[7:0];
        push_cmd(make_cmd(7'h2a, 1'b0, 1'b1, {pa, va}));
        push_cmd(make_cmd(7'h2a, 1'b0, 1'b0, {8'd0, pa}));
        push_cmd(make_cmd(7'h2a, 1'b1, 1'b0, 16'd0));
        push_cmd(make_cmd(7'h13, 1'b0, 1'b0, 16'd0));
        push_cmd(make_cmd(7'h2a, 1'b0, 1'b1, {pa, va}));
        for (int i = 0; i < 5; i++)
        begin
            wait_result(r);
            check_value("result.nack", (i == 3) ? 16'd1 : 16'd0, {15'd0, r.nack});
            if (i == 2)
                check_value("result.rdata", {8'd0, va}, r.rdata);
        end
        repeat (60) @(posedge clk);
        #1;
        assert (results.size() == 0)
        else
        begin
            $display("extra done pulses after the five queued commands");
            errors++;
        end
        assert (full_seen)
        else
        begin
            $display("queue never reported full during the burst");
            errors++;
        end
        end_test("queue_burst");

        $display("summary: %0d tests, %0d failed, %0d check errors", tests, failed, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: project.f
src/i2c_bus_pkg.sv
src/i2c_cmd_pkg.sv
src/i2c_cmd_fifo.sv
src/i2c_cmd_sequencer.sv
src/i2c_bus_master.sv
src/i2c_ctrl_top.sv
test/i2c_slave_model.sv
test/i2c_ctrl_checker.sv
test/tb_i2c_ctrl.sv

// File: run.sh
#!/bin/sh
# Build and run the I2C controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_i2c_ctrl -f project.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^>>> PASS$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
